// ==== verilog/cpu4_defines.svh ====
`ifndef CPU4_DEFINES_SVH
`define CPU4_DEFINES_SVH

// Nibble datapath width
`define CPU4_DATA_W 4

// Program counter width
`define CPU4_ADDR_W 12

// Phases per instruction word, A1 through X3
`define CPU4_PHASES 8

// Index register count
`define CPU4_NREGS 16

`endif

// ==== verilog/cpu4Pkg.sv ====
`default_nettype none

`include "cpu4_defines.svh"

package cpu4Pkg;

    // ==============================
    // Instruction classes, upper nibble
    // ==============================
    typedef enum logic [`CPU4_DATA_W-1:0] {
        opNop  = 4'h0,
        opJcn  = 4'h1,  // Conditional jump, two words
        opJun  = 4'h4,  // Unconditional jump, two words
        opInc  = 4'h6,
        opAdd  = 4'h8,
        opSub  = 4'h9,
        opLd   = 4'hA,
        opXch  = 4'hB,
        opLdm  = 4'hD,
        opFgrp = 4'hF   // Accumulator and carry group
    } opcodeE;

    // F-group subcodes, lower nibble
    typedef enum logic [`CPU4_DATA_W-1:0] {
        fClb = 4'h0,
        fClc = 4'h1,
        fIac = 4'h2,
        fCmc = 4'h3,
        fCma = 4'h4,
        fRal = 4'h5,
        fRar = 4'h6,
        fTcc = 4'h7,
        fDac = 4'h8,
        fTcs = 4'h9,
        fStc = 4'hA
    } fSubopE;

    // ==============================
    // Datapath control encodings
    // ==============================
    typedef enum logic [3:0] {
        aluPassReg, aluPassImm, aluAdd, aluSub, aluInc,
        aluClb, aluIac, aluCma, aluRal, aluRar,
        aluTcc, aluDac, aluTcs
    } aluOpE;

    typedef enum logic {srcReg, srcImm} aluSrcE;  // ALU operand B

    typedef enum logic [1:0] {seqIdle, seqRun, seqDone} seqStateE;

endpackage

`default_nettype wire

// ==== verilog/cpu4CtrlIf.sv ====
`default_nettype none

`include "cpu4_defines.svh"

interface cpu4CtrlIf;
    import cpu4Pkg::*;

    aluOpE                             aluOp;
    aluSrcE                            aluSrc;
    logic [`CPU4_DATA_W-1:0]           immNibble;   // Opa of the current word
    logic [$clog2(`CPU4_NREGS)-1:0]    regAddr;
    logic                              accWe;
    logic                              regWe;
    logic                              regSrcTemp;  // Register takes temp, for XCH
    logic                              tempWe;
    logic                              carryWe;
    logic                              carryNext;   // Fixed carry value
    logic                              zeroWe;

    modport decoder (output aluOp, aluSrc, immNibble, regAddr, accWe, regWe,
                     regSrcTemp, tempWe, carryWe, carryNext, zeroWe);

    modport datapath (input aluOp, aluSrc, immNibble, regAddr, accWe, regWe,
                      regSrcTemp, tempWe, carryWe, carryNext, zeroWe);

endinterface

`default_nettype wire

// ==== verilog/cycleSequencer.sv ====
`default_nettype none

`include "cpu4_defines.svh"

module cycleSequencer (
    input  wire                                clk,
    input  wire                                rstN,
    input  wire                                req,
    input  wire  [2*`CPU4_DATA_W-1:0]          instData,
    input  wire                                needImm,
    output logic                               ack,
    output logic [$clog2(`CPU4_PHASES)-1:0]    cycle,
    output logic [2*`CPU4_DATA_W-1:0]          instWord,
    output logic [2*`CPU4_DATA_W-1:0]          immWord,
    output logic                               immActive,
    output logic                               wordEnd
);
    import cpu4Pkg::*;

    localparam logic [$clog2(`CPU4_PHASES)-1:0] lastPhase =
        $clog2(`CPU4_PHASES)'(`CPU4_PHASES - 1);

    seqStateE state;
    logic     immPending;   // Next word is a jump's second byte
    logic     busy;
    logic     accept;

    assign busy    = (state == seqRun);
    assign accept  = (state == seqIdle) && req && !ack;
    assign wordEnd = busy && (cycle == lastPhase);  // X3

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= seqIdle;
            ack        <= 1'b0;
            cycle      <= '0;
            immPending <= 1'b0;
            immActive  <= 1'b0;
            instWord   <= '0;  // Decodes as NOP
        end else begin
            case (state)
                seqIdle: begin
                    if (accept) begin
                        state      <= seqRun;
                        cycle      <= '0;
                        immActive  <= immPending;
                        immPending <= 1'b0;
                        if (!immPending) begin
                            instWord <= instData;  // Opcode stays put over the second word
                        end
                    end
                end
                seqRun: begin
                    cycle <= cycle + 1'b1;  // Wraps to A1 after X3
                    if (wordEnd) begin
                        state      <= seqDone;
                        ack        <= 1'b1;
                        immPending <= needImm;
                    end
                end
                seqDone: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= seqIdle;
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // Second byte of a two-word jump
    always_ff @(posedge clk) begin
        if (accept && immPending) begin
            immWord <= instData;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`default_nettype none

`include "cpu4_defines.svh"

module instrDecoder (
    input  wire  [2*`CPU4_DATA_W-1:0]          instWord,
    input  wire                                immActive,
    input  wire  [$clog2(`CPU4_PHASES)-1:0]    cycle,
    input  wire                                wordEnd,
    input  wire                                carry,
    input  wire                                zero,
    input  wire                                testFlag,
    cpu4CtrlIf.decoder                         ctrl,
    output logic                               needImm,
    output logic                               pcLoad
);
    import cpu4Pkg::*;

    localparam logic [$clog2(`CPU4_PHASES)-1:0] x1Phase = 3'd5;

    opcodeE                  opcode;
    fSubopE                  fOp;
    logic [`CPU4_DATA_W-1:0] opa;
    logic                    condRaw;
    logic                    condTrue;

    assign opcode = opcodeE'(instWord[2*`CPU4_DATA_W-1:`CPU4_DATA_W]);
    assign opa    = instWord[`CPU4_DATA_W-1:0];
    assign fOp    = fSubopE'(opa);

    // ==============================
    // JCN condition
    // ==============================
    assign condRaw  = (opa[0] & ~testFlag) | (opa[1] & carry) | (opa[2] & zero);
    assign condTrue = opa[3] ? ~condRaw : condRaw;  // Bit 3 inverts

    always_comb begin
        ctrl.aluOp      = aluPassReg;
        ctrl.aluSrc     = srcReg;
        ctrl.immNibble  = opa;
        ctrl.regAddr    = opa;
        ctrl.accWe      = 1'b0;
        ctrl.regWe      = 1'b0;
        ctrl.regSrcTemp = 1'b0;
        ctrl.tempWe     = (cycle == x1Phase);  // Temp takes acc at X1 on every word
        ctrl.carryWe    = 1'b0;
        ctrl.carryNext  = 1'b0;
        ctrl.zeroWe     = 1'b0;
        needImm         = 1'b0;
        pcLoad          = 1'b0;

        case (opcode)
            opJun, opJcn: begin
                if (wordEnd) begin
                    needImm = !immActive;  // First word asks for the address byte
                    pcLoad  = immActive && ((opcode == opJun) || condTrue);
                end
            end
            opInc: begin
                ctrl.aluOp = aluInc;
                ctrl.regWe = wordEnd;  // Flags untouched
            end
            opAdd, opSub: begin
                ctrl.aluOp   = (opcode == opAdd) ? aluAdd : aluSub;
                ctrl.accWe   = wordEnd;
                ctrl.carryWe = wordEnd;
                ctrl.zeroWe  = wordEnd;
            end
            opLd: begin
                ctrl.accWe  = wordEnd;
                ctrl.zeroWe = wordEnd;
            end
            opXch: begin
                ctrl.accWe      = wordEnd;  // Acc gets the register through the ALU
                ctrl.regWe      = wordEnd;
                ctrl.regSrcTemp = 1'b1;
            end
            opLdm: begin
                ctrl.aluOp  = aluPassImm;
                ctrl.aluSrc = srcImm;
                ctrl.accWe  = wordEnd;
                ctrl.zeroWe = wordEnd;
            end
            opFgrp: begin
                case (fOp)
                    fClb: begin
                        ctrl.aluOp   = aluClb;
                        ctrl.accWe   = wordEnd;
                        ctrl.carryWe = wordEnd;
                    end
                    fClc: ctrl.carryWe = wordEnd;
                    fIac, fDac: begin
                        ctrl.aluOp   = (fOp == fIac) ? aluIac : aluDac;
                        ctrl.accWe   = wordEnd;
                        ctrl.carryWe = wordEnd;
                        ctrl.zeroWe  = wordEnd;
                    end
                    fCmc: begin
                        ctrl.carryWe   = wordEnd;
                        ctrl.carryNext = ~carry;
                    end
                    fCma: begin
                        ctrl.aluOp = aluCma;
                        ctrl.accWe = wordEnd;
                    end
                    fRal, fRar: begin
                        ctrl.aluOp   = (fOp == fRal) ? aluRal : aluRar;
                        ctrl.accWe   = wordEnd;
                        ctrl.carryWe = wordEnd;  // Shifted-out bit
                    end
                    fTcc, fTcs: begin
                        ctrl.aluOp   = (fOp == fTcc) ? aluTcc : aluTcs;
                        ctrl.accWe   = wordEnd;
                        ctrl.carryWe = wordEnd;  // Cleared after transfer
                    end
                    fStc: begin
                        ctrl.carryWe   = wordEnd;
                        ctrl.carryNext = 1'b1;
                    end
                    default: ;  // Reserved E and F
                endcase
            end
            default: ;  // Unsupported classes run as NOP
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/aluUnit.sv ====
`default_nettype none

`include "cpu4_defines.svh"

module aluUnit (
    cpu4CtrlIf.datapath                   ctrl,
    input  wire  [`CPU4_DATA_W-1:0]       accVal,
    input  wire  [`CPU4_DATA_W-1:0]       regVal,
    input  wire                           carryIn,
    output logic [`CPU4_DATA_W-1:0]       result,
    output logic                          carryOut,
    output logic                          zeroOut
);
    import cpu4Pkg::*;

    logic [`CPU4_DATA_W-1:0] bOp;
    logic [`CPU4_DATA_W:0]   accExt;
    logic [`CPU4_DATA_W:0]   bExt;
    logic [`CPU4_DATA_W:0]   cinExt;

    assign bOp    = (ctrl.aluSrc == srcImm) ? ctrl.immNibble : regVal;
    assign accExt = {1'b0, accVal};
    assign bExt   = {1'b0, bOp};
    assign cinExt = {{`CPU4_DATA_W{1'b0}}, carryIn};

    always_comb begin
        result   = '0;
        carryOut = 1'b0;
        case (ctrl.aluOp)
            aluPassReg, aluPassImm: result = bOp;
            aluAdd: {carryOut, result} = accExt + bExt + cinExt;
            aluSub: begin
                // Carry set afterwards means no borrow
                {carryOut, result} = accExt + {1'b0, ~bOp} + {{`CPU4_DATA_W{1'b0}}, ~carryIn};
            end
            aluIac: {carryOut, result} = accExt + 1'b1;
            aluDac: {carryOut, result} = accExt + {1'b0, {`CPU4_DATA_W{1'b1}}};
            aluInc: result = bOp + 1'b1;
            aluRal: {carryOut, result} = {accVal, carryIn};
            aluRar: {result, carryOut} = {carryIn, accVal};
            aluCma: result = ~accVal;
            aluTcc: result = cinExt[`CPU4_DATA_W-1:0];
            aluTcs: result = carryIn ? 4'd10 : 4'd9;
            aluClb: result = '0;
            default: result = '0;
        endcase
    end

    assign zeroOut = (result == '0);

endmodule

`default_nettype wire

// ==== verilog/datapathRegs.sv ====
`default_nettype none

`include "cpu4_defines.svh"

module datapathRegs (
    input  wire                           clk,
    input  wire                           rstN,
    cpu4CtrlIf.datapath                   ctrl,
    input  wire  [`CPU4_DATA_W-1:0]       aluResult,
    input  wire                           aluCarry,
    input  wire                           aluZero,
    output logic [`CPU4_DATA_W-1:0]       acc,
    output logic [`CPU4_DATA_W-1:0]       regVal,
    output logic                          carry,
    output logic                          zero
);
    import cpu4Pkg::*;

    logic [`CPU4_DATA_W-1:0] accReg;
    logic [`CPU4_DATA_W-1:0] tempReg;
    logic [`CPU4_DATA_W-1:0] regFile [`CPU4_NREGS];
    logic                    carryReg;
    logic                    zeroReg;
    logic                    useAluCarry;
    logic [`CPU4_DATA_W-1:0] regWrData;

    // Arithmetic and rotates take the ALU carry, the rest a fixed value
    assign useAluCarry = ctrl.aluOp inside {aluAdd, aluSub, aluIac, aluDac, aluRal, aluRar};
    assign regWrData   = ctrl.regSrcTemp ? tempReg : aluResult;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            accReg   <= '0;
            carryReg <= 1'b0;
            zeroReg  <= 1'b0;
            for (int i = 0; i < `CPU4_NREGS; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            if (ctrl.accWe) accReg <= aluResult;
            if (ctrl.regWe) regFile[ctrl.regAddr] <= regWrData;
            if (ctrl.carryWe) carryReg <= useAluCarry ? aluCarry : ctrl.carryNext;
            if (ctrl.zeroWe) zeroReg <= aluZero;
        end
    end

    // Snapshot of acc at X1
    always_ff @(posedge clk) begin
        if (ctrl.tempWe) begin
            tempReg <= accReg;
        end
    end

    assign acc    = accReg;
    assign regVal = regFile[ctrl.regAddr];
    assign carry  = carryReg;
    assign zero   = zeroReg;

endmodule

`default_nettype wire

// ==== verilog/programCounter.sv ====
`default_nettype none

`include "cpu4_defines.svh"

module programCounter (
    input  wire                           clk,
    input  wire                           rstN,
    input  wire                           wordEnd,
    input  wire                           pcLoad,
    input  wire  [`CPU4_ADDR_W-1:0]       jumpTarget,
    output logic [`CPU4_ADDR_W-1:0]       pc
);

    logic [`CPU4_ADDR_W-1:0] pcReg;
    logic [`CPU4_ADDR_W-1:0] pcNext;

    // Jump replaces the increment on the same edge
    always_comb begin
        pcNext = pcReg + 1'b1;
        if (pcLoad) begin
            pcNext = jumpTarget;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg <= '0;
        end else if (wordEnd) begin  // End of X3
            pcReg <= pcNext;
        end
    end

    assign pc = pcReg;

endmodule

`default_nettype wire

// ==== verilog/cpu4Top.sv ====
`default_nettype none

`include "cpu4_defines.svh"

module cpu4Top (
    input  wire                           clk,
    input  wire                           rstN,
    input  wire                           req,
    input  wire  [2*`CPU4_DATA_W-1:0]     instData,
    input  wire                           testFlag,
    output logic                          ack,
    output logic [`CPU4_DATA_W-1:0]       acc,
    output logic                          carry,
    output logic                          zero,
    output logic [`CPU4_ADDR_W-1:0]       pc
);
    import cpu4Pkg::*;

    logic [$clog2(`CPU4_PHASES)-1:0] cycle;
    logic [2*`CPU4_DATA_W-1:0]       instWord;
    logic [2*`CPU4_DATA_W-1:0]       immWord;
    logic                            immActive;
    logic                            wordEnd;
    logic                            needImm;
    logic                            pcLoad;
    logic [`CPU4_DATA_W-1:0]         aluResult;
    logic                            aluCarry;
    logic                            aluZero;
    logic [`CPU4_DATA_W-1:0]         regVal;
    logic [`CPU4_ADDR_W-1:0]         pcInc;
    logic [`CPU4_ADDR_W-1:0]         jumpTarget;

    cpu4CtrlIf ctrlBus ();

    // ==============================
    // Jump target
    // ==============================
    assign pcInc      = pc + 1'b1;  // JCN stays in the page after the second word
    assign jumpTarget = (opcodeE'(instWord[2*`CPU4_DATA_W-1:`CPU4_DATA_W]) == opJun)
                      ? {instWord[`CPU4_DATA_W-1:0], immWord}
                      : {pcInc[`CPU4_ADDR_W-1:2*`CPU4_DATA_W], immWord};

    cycleSequencer cycleSequencer_inst (
        .clk(clk), .rstN(rstN), .req(req), .instData(instData), .needImm(needImm),
        .ack(ack), .cycle(cycle), .instWord(instWord), .immWord(immWord),
        .immActive(immActive), .wordEnd(wordEnd)
    );

    instrDecoder instrDecoder_inst (
        .instWord(instWord), .immActive(immActive), .cycle(cycle), .wordEnd(wordEnd),
        .carry(carry), .zero(zero), .testFlag(testFlag), .ctrl(ctrlBus.decoder),
        .needImm(needImm), .pcLoad(pcLoad)
    );

    aluUnit aluUnit_inst (
        .ctrl(ctrlBus.datapath), .accVal(acc), .regVal(regVal), .carryIn(carry),
        .result(aluResult), .carryOut(aluCarry), .zeroOut(aluZero)
    );

    datapathRegs datapathRegs_inst (
        .clk(clk), .rstN(rstN), .ctrl(ctrlBus.datapath), .aluResult(aluResult),
        .aluCarry(aluCarry), .aluZero(aluZero), .acc(acc), .regVal(regVal),
        .carry(carry), .zero(zero)
    );

    programCounter programCounter_inst (
        .clk(clk), .rstN(rstN), .wordEnd(wordEnd), .pcLoad(pcLoad),
        .jumpTarget(jumpTarget), .pc(pc)
    );

endmodule

`default_nettype wire

// ==== sim/cpu4Tb.sv ====
`default_nettype none

`include "cpu4_defines.svh"

module cpu4Tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [2*`CPU4_DATA_W-1:0] instByte;
        logic                      testFlag;
        logic [`CPU4_DATA_W-1:0]   expAcc;
        logic                      expCarry;
        logic                      expZero;
        logic [`CPU4_ADDR_W-1:0]   expPc;
    } rowT;

    logic                        clk = 1'b0;
    logic                        rstN;
    logic                        req;
    logic [2*`CPU4_DATA_W-1:0]   instData;
    logic                        testFlag;
    logic                        ack;
    logic [`CPU4_DATA_W-1:0]     acc;
    logic                        carry;
    logic                        zero;
    logic [`CPU4_ADDR_W-1:0]     pc;

    rowT   rows[$];
    string rowNames[$];
    int    errorCount = 0;
    logic  tableReady = 1'b0;

    always #2 clk = ~clk;  // 4 ns period

    cpu4Top cpu4Top_inst (
        .clk(clk), .rstN(rstN), .req(req), .instData(instData), .testFlag(testFlag),
        .ack(ack), .acc(acc), .carry(carry), .zero(zero), .pc(pc)
    );

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("error: %s expected 0x%0h actual 0x%0h", testName, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic addRow(input string name, input logic [7:0] instByte, input logic tf,
                          input logic [3:0] expAcc, input logic expCarry,
                          input logic expZero, input logic [11:0] expPc);
        rowT row;
        row.instByte = instByte;
        row.testFlag = tf;
        row.expAcc   = expAcc;
        row.expCarry = expCarry;
        row.expZero  = expZero;
        row.expPc    = expPc;
        rows.push_back(row);
        rowNames.push_back(name);
    endtask

    // ==============================
    // Stimulus and expected state
    // ==============================
    // Columns: name, byte, testFlag, acc, carry, zero, pc after ack
    task automatic loadTable();
        addRow("NOP after reset",     8'h00, 1'b0, 4'h0, 1'b0, 1'b0, 12'h001);
        addRow("LDM 5",               8'hD5, 1'b0, 4'h5, 1'b0, 1'b0, 12'h002);
        addRow("XCH r1",              8'hB1, 1'b0, 4'h0, 1'b0, 1'b0, 12'h003);
        addRow("LDM 0",               8'hD0, 1'b0, 4'h0, 1'b0, 1'b1, 12'h004);
        addRow("LD r1",               8'hA1, 1'b0, 4'h5, 1'b0, 1'b0, 12'h005);
        addRow("LDM 9",               8'hD9, 1'b0, 4'h9, 1'b0, 1'b0, 12'h006);
        addRow("XCH r2 keeps zero",   8'hB2, 1'b0, 4'h0, 1'b0, 1'b0, 12'h007);
        addRow("LDM 7",               8'hD7, 1'b0, 4'h7, 1'b0, 1'b0, 12'h008);
        addRow("ADD r2 wrap",         8'h82, 1'b0, 4'h0, 1'b1, 1'b1, 12'h009);
        addRow("ADD r1 carry in",     8'h81, 1'b0, 4'h6, 1'b0, 1'b0, 12'h00A);
        addRow("SUB r1 no borrow",    8'h91, 1'b0, 4'h1, 1'b1, 1'b0, 12'h00B);
        addRow("SUB r2 borrow",       8'h92, 1'b0, 4'h7, 1'b0, 1'b0, 12'h00C);
        addRow("SUB r1 after borrow", 8'h91, 1'b0, 4'h2, 1'b1, 1'b0, 12'h00D);
        addRow("INC r3",              8'h63, 1'b0, 4'h2, 1'b1, 1'b0, 12'h00E);
        addRow("SUB r3 zero",         8'h93, 1'b0, 4'h0, 1'b1, 1'b1, 12'h00F);
        addRow("INC r1 flags kept",   8'h61, 1'b0, 4'h0, 1'b1, 1'b1, 12'h010);
        addRow("LD r1 after INC",     8'hA1, 1'b0, 4'h6, 1'b1, 1'b0, 12'h011);
        // F group
        addRow("CLB",                 8'hF0, 1'b0, 4'h0, 1'b0, 1'b0, 12'h012);
        addRow("STC",                 8'hFA, 1'b0, 4'h0, 1'b1, 1'b0, 12'h013);
        addRow("CMC set",             8'hF3, 1'b0, 4'h0, 1'b0, 1'b0, 12'h014);
        addRow("CMC clear",           8'hF3, 1'b0, 4'h0, 1'b1, 1'b0, 12'h015);
        addRow("CLC",                 8'hF1, 1'b0, 4'h0, 1'b0, 1'b0, 12'h016);
        addRow("IAC",                 8'hF2, 1'b0, 4'h1, 1'b0, 1'b0, 12'h017);
        addRow("LDM 15",              8'hDF, 1'b0, 4'hF, 1'b0, 1'b0, 12'h018);
        addRow("IAC wrap",            8'hF2, 1'b0, 4'h0, 1'b1, 1'b1, 12'h019);
        addRow("DAC borrow",          8'hF8, 1'b0, 4'hF, 1'b0, 1'b0, 12'h01A);
        addRow("DAC no borrow",       8'hF8, 1'b0, 4'hE, 1'b1, 1'b0, 12'h01B);
        addRow("CMA",                 8'hF4, 1'b0, 4'h1, 1'b1, 1'b0, 12'h01C);
        addRow("RAL carry in",        8'hF5, 1'b0, 4'h3, 1'b0, 1'b0, 12'h01D);
        addRow("LDM 9 again",         8'hD9, 1'b0, 4'h9, 1'b0, 1'b0, 12'h01E);
        addRow("RAL carry out",       8'hF5, 1'b0, 4'h2, 1'b1, 1'b0, 12'h01F);
        addRow("RAR carry in",        8'hF6, 1'b0, 4'h9, 1'b0, 1'b0, 12'h020);
        addRow("RAR carry out",       8'hF6, 1'b0, 4'h4, 1'b1, 1'b0, 12'h021);
        addRow("TCC set",             8'hF7, 1'b0, 4'h1, 1'b0, 1'b0, 12'h022);
        addRow("TCC clear",           8'hF7, 1'b0, 4'h0, 1'b0, 1'b0, 12'h023);
        addRow("TCS carry clear",     8'hF9, 1'b0, 4'h9, 1'b0, 1'b0, 12'h024);
        addRow("STC before TCS",      8'hFA, 1'b0, 4'h9, 1'b1, 1'b0, 12'h025);
        addRow("TCS carry set",       8'hF9, 1'b0, 4'hA, 1'b0, 1'b0, 12'h026);
        addRow("reserved FE",         8'hFE, 1'b0, 4'hA, 1'b0, 1'b0, 12'h027);
        addRow("FIM as NOP",          8'h20, 1'b0, 4'hA, 1'b0, 1'b0, 12'h028);
        // Jumps, second words are rows of their own
        addRow("JUN word 1",          8'h41, 1'b0, 4'hA, 1'b0, 1'b0, 12'h029);
        addRow("JUN word 2",          8'h23, 1'b0, 4'hA, 1'b0, 1'b0, 12'h123);
        addRow("NOP after JUN",       8'h00, 1'b0, 4'hA, 1'b0, 1'b0, 12'h124);
        addRow("JCN test low 1",      8'h11, 1'b0, 4'hA, 1'b0, 1'b0, 12'h125);
        addRow("JCN test low 2",      8'h50, 1'b0, 4'hA, 1'b0, 1'b0, 12'h150);
        addRow("JCN test high 1",     8'h11, 1'b1, 4'hA, 1'b0, 1'b0, 12'h151);
        addRow("JCN test high 2",     8'h60, 1'b1, 4'hA, 1'b0, 1'b0, 12'h152);
        addRow("STC for JCN",         8'hFA, 1'b0, 4'hA, 1'b1, 1'b0, 12'h153);
        addRow("JCN carry 1",         8'h12, 1'b0, 4'hA, 1'b1, 1'b0, 12'h154);
        addRow("JCN carry 2",         8'h70, 1'b0, 4'hA, 1'b1, 1'b0, 12'h170);
        addRow("JCN no carry 1",      8'h1A, 1'b0, 4'hA, 1'b1, 1'b0, 12'h171);
        addRow("JCN no carry 2",      8'h80, 1'b0, 4'hA, 1'b1, 1'b0, 12'h172);
        addRow("JCN zero clear 1",    8'h14, 1'b0, 4'hA, 1'b1, 1'b0, 12'h173);
        addRow("JCN zero clear 2",    8'h90, 1'b0, 4'hA, 1'b1, 1'b0, 12'h174);
        addRow("LDM 0 for JCN",       8'hD0, 1'b0, 4'h0, 1'b1, 1'b1, 12'h175);
        addRow("JCN zero set 1",      8'h14, 1'b0, 4'h0, 1'b1, 1'b1, 12'h176);
        addRow("JCN zero set 2",      8'hA0, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1A0);
        addRow("JCN not zero 1",      8'h1C, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1A1);
        addRow("JCN not zero 2",      8'hB0, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1A2);
        addRow("JCN inverted none 1", 8'h18, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1A3);
        addRow("JCN inverted none 2", 8'hC4, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1C4);
        addRow("JUN to page end 1",   8'h41, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1C5);
        addRow("JUN to page end 2",   8'hFE, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1FE);
        addRow("JCN page cross 1",    8'h18, 1'b0, 4'h0, 1'b1, 1'b1, 12'h1FF);
        addRow("JCN page cross 2",    8'h33, 1'b0, 4'h0, 1'b1, 1'b1, 12'h233);
    endtask

    // Four-phase transaction, entered and left on a falling edge
    task automatic runWord(input int idx);
        rowT row;
        row      = rows[idx];
        instData = row.instByte;
        testFlag = row.testFlag;
        req      = 1'b1;
        do begin
            @(negedge clk);
        end while (!ack);
        checkValue({rowNames[idx], " acc"}, 32'(row.expAcc), 32'(acc));
        checkValue({rowNames[idx], " carry"}, 32'(row.expCarry), 32'(carry));
        checkValue({rowNames[idx], " zero"}, 32'(row.expZero), 32'(zero));
        checkValue({rowNames[idx], " pc"}, 32'(row.expPc), 32'(pc));
        req = 1'b0;
        do begin
            @(negedge clk);
        end while (ack);  // Core drops ack after req low
    endtask

    initial begin
        rstN     = 1'b0;
        req      = 1'b0;
        instData = '0;
        testFlag = 1'b0;
        loadTable();
        tableReady = 1'b1;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("reset ack", 32'd0, 32'(ack));
        checkValue("reset acc", 32'd0, 32'(acc));
        checkValue("reset carry", 32'd0, 32'(carry));
        checkValue("reset zero", 32'd0, 32'(zero));
        checkValue("reset pc", 32'd0, 32'(pc));
        for (int i = 0; i < rows.size(); i++) begin
            runWord(i);
        end
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog, 14 cycles of 4 ns per row plus margin
    initial begin
        wait (tableReady);
        #(rows.size() * 14 * 4 + 100);
        $display("timeout: the core did not finish the handshakes in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/cpu4Pkg.sv
verilog/cpu4CtrlIf.sv
verilog/cycleSequencer.sv
verilog/instrDecoder.sv
verilog/aluUnit.sv
verilog/datapathRegs.sv
verilog/programCounter.sv
verilog/cpu4Top.sv
sim/cpu4Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu4 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module cpu4Tb -o cpu4Sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpu4Sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF "Simulation finished: PASS"; then
    exit 0
fi
exit 1
